//--- rtl/core_params.svh
// --------------------------------------------------------------------------
// sizes and the fixed non-cacheable window of the data memory system
// addresses are byte addresses, the bus carries word addresses
// an address is uncached when (addr & ~CORE_NC_MASK) == CORE_NC_BASE
// --------------------------------------------------------------------------
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// byte address width, 4 KB space
`define CORE_ADDR_W 12

// backing ram depth in 32-bit words
`define CORE_RAM_WORDS 1024

// l1 data cache, one word per line
`define CORE_L1D_LINES 8

// top quarter of the ram bypasses the cache
`define CORE_NC_BASE 12'hC00
`define CORE_NC_MASK 12'h3FF

`endif

//--- rtl/core_pkg.sv
// --------------------------------------------------------------------------
// shared types of the memory stage and the data memory system
// bus_req_t carries a word address, byte lanes come from be
// --------------------------------------------------------------------------
`include "core_params.svh"

package core_pkg;

	// access size of a load or store
	typedef enum logic [1:0] {
		SZ_BYTE = 2'd0,
		SZ_HALF = 2'd1,
		SZ_WORD = 2'd2
	} acc_size_t;

	// executed instruction entering the memory stage
	typedef struct packed {
		logic        valid;
		logic        load;
		logic        store;
		acc_size_t   size;
		logic        sign_ext;
		logic        reg_we;
		logic [4:0]  rd;
		logic [31:0] alu_result;
		logic [31:0] st_data;
		logic        bp_sel;
		logic [31:0] bp_data;
	} mem_op_t;

	// write-back result
	typedef struct packed {
		logic        valid;
		logic        reg_we;
		logic [4:0]  rd;
		logic [31:0] data;
	} wb_res_t;

	// one request on a four-phase bus link
	typedef struct packed {
		logic [`CORE_ADDR_W-3:0] addr;
		logic                    we;
		logic [3:0]              be;
		logic [31:0]             wdata;
	} bus_req_t;

	// one data word seen as word, bytes or halfwords
	typedef union packed {
		logic [31:0]      word;
		logic [3:0][7:0]  bytes;
		logic [1:0][15:0] halves;
	} load_word_u;

endpackage

//--- rtl/mem_stage.sv
// --------------------------------------------------------------------------
// memory stage with one instruction per four-phase op_req/op_ack transaction
// accesses are assumed naturally aligned with no misalignment trap
// cacheable accesses use the c_ port and the fixed window uses the u_ port
// res is held while op_ack is high
// --------------------------------------------------------------------------
`include "core_params.svh"

module mem_stage import core_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        op_req,
	input  mem_op_t     op,
	output logic        op_ack,
	output wb_res_t     res,
	output logic        c_req,
	output bus_req_t    c_bus,
	input  logic        c_ack,
	input  logic [31:0] c_rdata,
	output logic        u_req,
	output bus_req_t    u_bus,
	input  logic        u_ack,
	input  logic [31:0] u_rdata
);

	typedef enum logic [1:0] {ST_IDLE, ST_ACCESS, ST_DONE} st_t;

	st_t         state;
	mem_op_t     op_q;
	logic        nc_q;
	logic        is_mem;
	logic        op_nc;
	logic [31:0] st_sel;
	logic [3:0]  be;
	bus_req_t    req_bus;
	logic        port_ack;
	logic [31:0] port_rdata;
	load_word_u  lw;
	logic [7:0]  lane_b;
	logic [15:0] lane_h;
	logic [31:0] ld_val;

	// --------------------------------------------------------------------------
	// request side
	// --------------------------------------------------------------------------
	assign is_mem = op.valid && (op.load || op.store);
	// fixed window decode on the incoming address
	assign op_nc = (op.alu_result[`CORE_ADDR_W-1:0] & ~`CORE_NC_MASK) == `CORE_NC_BASE;

	always_comb begin
		// write-back bypass wins over register data
		st_sel = op_q.bp_sel ? op_q.bp_data : op_q.st_data;
		case (op_q.size)
			SZ_BYTE: be = 4'b0001 << op_q.alu_result[1:0];
			SZ_HALF: be = 4'b0011 << {op_q.alu_result[1], 1'b0};
			default: be = 4'b1111;
		endcase
		req_bus.addr  = op_q.alu_result[`CORE_ADDR_W-1:2];
		req_bus.we    = op_q.store;
		// loads fetch the full word
		req_bus.be    = op_q.store ? be : 4'b1111;
		req_bus.wdata = st_sel << {op_q.alu_result[1:0], 3'b000};
	end

	assign c_bus = req_bus;
	assign u_bus = req_bus;
	// exactly one port per access
	assign c_req = (state == ST_ACCESS) && !nc_q;
	assign u_req = (state == ST_ACCESS) && nc_q;

	// --------------------------------------------------------------------------
	// load alignment
	// --------------------------------------------------------------------------
	assign port_ack   = nc_q ? u_ack : c_ack;
	assign port_rdata = nc_q ? u_rdata : c_rdata;

	always_comb begin
		lw.word = port_rdata;
		lane_b  = lw.bytes[op_q.alu_result[1:0]];
		lane_h  = lw.halves[op_q.alu_result[1]];
		case (op_q.size)
			SZ_BYTE: ld_val = {{24{op_q.sign_ext & lane_b[7]}}, lane_b};
			SZ_HALF: ld_val = {{16{op_q.sign_ext & lane_h[15]}}, lane_h};
			default: ld_val = lw.word;
		endcase
	end

	// op latch for the access phase
	always_ff @(posedge clk) begin
		if (state == ST_IDLE && op_req) begin
			op_q <= op;
			nc_q <= op_nc;
		end
	end

	// handshake fsm and write-back register
	always_ff @(posedge clk) begin
		if (rst) begin
			state  <= ST_IDLE;
			op_ack <= 1'b0;
			res    <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (op_req && is_mem) begin
						state <= ST_ACCESS;
					end else if (op_req) begin
						// non-memory op takes its result straight from the alu
						res.valid  <= op.valid;
						res.reg_we <= op.reg_we;
						res.rd     <= op.rd;
						res.data   <= op.alu_result;
						op_ack     <= 1'b1;
						state      <= ST_DONE;
					end
				end
				ST_ACCESS: begin
					if (port_ack) begin
						res.valid  <= op_q.valid;
						res.reg_we <= op_q.reg_we;
						res.rd     <= op_q.rd;
						res.data   <= op_q.load ? ld_val : op_q.alu_result;
						op_ack     <= 1'b1;
						state      <= ST_DONE;
					end
				end
				default: begin
					// both handshakes back to zero before the next op
					if (!op_req && !port_ack) begin
						op_ack <= 1'b0;
						state  <= ST_IDLE;
					end
				end
			endcase
		end
	end

	// one port at a time and the chosen port matches the bus address window
	a_one_port: assert property (@(posedge clk) disable iff (rst)
		(c_req || u_req) |-> (!(c_req && u_req) &&
			(u_req == (({u_bus.addr, 2'b00} & ~`CORE_NC_MASK) == `CORE_NC_BASE))));

endmodule

//--- rtl/l1d_cache.sv
// --------------------------------------------------------------------------
// direct-mapped l1 data cache with one word per line
// write-through without write allocate, so stores always go to the bus
// one request at a time on the four-phase c_ link
// --------------------------------------------------------------------------
`include "core_params.svh"

module l1d_cache import core_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        c_req,
	input  bus_req_t    c_bus,
	output logic        c_ack,
	output logic [31:0] c_rdata,
	output logic        m_req,
	output bus_req_t    m_bus,
	input  logic        m_ack,
	input  logic [31:0] m_rdata
);

	localparam int IDX_W = $clog2(`CORE_L1D_LINES);
	localparam int TAG_W = `CORE_ADDR_W - 2 - IDX_W;

	typedef enum logic [1:0] {C_IDLE, C_BUS, C_WAIT} cst_t;

	cst_t                       state;
	logic [31:0]                line_data [`CORE_L1D_LINES];
	logic [TAG_W-1:0]           line_tag [`CORE_L1D_LINES];
	logic [`CORE_L1D_LINES-1:0] line_vld;
	bus_req_t                   req_q;
	logic                       hit_q;
	logic [IDX_W-1:0]           idx;
	logic [IDX_W-1:0]           idx_q;
	logic [TAG_W-1:0]           tag;
	logic                       hit;
	load_word_u                 old_w;
	load_word_u                 new_w;
	load_word_u                 merged;

	// lookup on the incoming request
	assign idx   = c_bus.addr[IDX_W-1:0];
	assign tag   = c_bus.addr[`CORE_ADDR_W-3:IDX_W];
	assign hit   = line_vld[idx] && (line_tag[idx] == tag);
	assign idx_q = req_q.addr[IDX_W-1:0];

	// byte merge of a store hit into its line
	always_comb begin
		old_w.word = line_data[idx_q];
		new_w.word = req_q.wdata;
		for (int i = 0; i < 4; i++) begin
			merged.bytes[i] = req_q.be[i] ? new_w.bytes[i] : old_w.bytes[i];
		end
	end

	assign m_req = (state == C_BUS);
	assign m_bus = req_q;

	// --------------------------------------------------------------------------
	// control fsm and line valid bits
	// --------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= C_IDLE;
			c_ack    <= 1'b0;
			line_vld <= '0;
		end else begin
			case (state)
				C_IDLE: begin
					if (c_req && !c_bus.we && hit) begin
						// read hit acks next cycle
						c_ack <= 1'b1;
						state <= C_WAIT;
					end else if (c_req) begin
						state <= C_BUS;
					end
				end
				C_BUS: begin
					if (m_ack) begin
						c_ack <= 1'b1;
						state <= C_WAIT;
						if (!req_q.we) begin
							line_vld[idx_q] <= 1'b1;
						end
					end
				end
				default: begin
					if (!c_req && !m_ack) begin
						c_ack <= 1'b0;
						state <= C_IDLE;
					end
				end
			endcase
		end
	end

	// line storage and request latch
	always_ff @(posedge clk) begin
		if (state == C_IDLE && c_req) begin
			req_q   <= c_bus;
			hit_q   <= hit;
			c_rdata <= line_data[idx];
		end
		if (state == C_BUS && m_ack) begin
			if (!req_q.we) begin
				// refill
				line_data[idx_q] <= m_rdata;
				line_tag[idx_q]  <= req_q.addr[`CORE_ADDR_W-3:IDX_W];
				c_rdata          <= m_rdata;
			end else if (hit_q) begin
				line_data[idx_q] <= merged.word;
			end
		end
	end

	// bus used only inside a stage request, by a read miss or a store
	a_idle_no_bus: assert property (@(posedge clk) disable iff (rst)
		m_req |-> (c_req && (req_q.we || !hit_q)));

endmodule

//--- rtl/mem_bus_arbiter.sv
// --------------------------------------------------------------------------
// round-robin arbiter joining two four-phase masters onto one slave
// grants only when idle and adds one cycle from master req to s_req
// grant held until the master req and the slave ack are both low
// --------------------------------------------------------------------------
module mem_bus_arbiter import core_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     m0_req,
	input  logic     m1_req,
	input  bus_req_t m0,
	input  bus_req_t m1,
	output logic     m0_ack,
	output logic     m1_ack,
	output logic     s_req,
	output bus_req_t s,
	input  logic     s_ack
);

	logic gnt_vld;
	logic gnt_id;
	logic gnt_done;
	logic last_win;
	logic sel_req;
	logic pick;

	always_comb begin
		sel_req = gnt_id ? m1_req : m0_req;
		// on a tie the loser of the last round goes first
		if (m0_req && m1_req) begin
			pick = ~last_win;
		end else begin
			pick = m1_req;
		end
	end

	// mux of the granted master
	assign s_req  = gnt_vld && !gnt_done && sel_req;
	assign s      = gnt_id ? m1 : m0;
	assign m0_ack = gnt_vld && !gnt_id && s_ack;
	assign m1_ack = gnt_vld && gnt_id && s_ack;

	always_ff @(posedge clk) begin
		if (rst) begin
			gnt_vld  <= 1'b0;
			gnt_id   <= 1'b0;
			gnt_done <= 1'b0;
			last_win <= 1'b0;
		end else if (!gnt_vld) begin
			if (m0_req || m1_req) begin
				gnt_vld  <= 1'b1;
				gnt_id   <= pick;
				gnt_done <= 1'b0;
				last_win <= pick;
			end
		end else begin
			// after the master drops req wait for the slave ack to fall
			if (!sel_req) begin
				gnt_done <= 1'b1;
			end
			if (gnt_done && !s_ack) begin
				gnt_vld <= 1'b0;
			end
		end
	end

	// a rising slave ack lands on a granted master that still requests
	a_ack_route: assert property (@(posedge clk) disable iff (rst)
		$rose(s_ack) |-> (gnt_vld && (gnt_id ? m1_req : m0_req)));

endmodule

//--- rtl/data_ram.sv
// --------------------------------------------------------------------------
// word-organized backing ram as a four-phase bus slave
// s_ack rises one cycle after s_req, falls one cycle after it falls
// writes land on the edge that raises s_ack, read data valid with s_ack
// --------------------------------------------------------------------------
`include "core_params.svh"

module data_ram import core_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        s_req,
	input  bus_req_t    s,
	output logic        s_ack,
	output logic [31:0] rdata
);

	logic [31:0] mem [`CORE_RAM_WORDS];

	// ack follows req by one cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			s_ack <= 1'b0;
		end else begin
			s_ack <= s_req;
		end
	end

	// access only on the first cycle of a request
	always_ff @(posedge clk) begin
		if (s_req && !s_ack) begin
			if (s.we) begin
				for (int i = 0; i < 4; i++) begin
					if (s.be[i]) begin
						mem[s.addr][i*8 +: 8] <= s.wdata[i*8 +: 8];
					end
				end
			end
			rdata <= mem[s.addr];
		end
	end

endmodule

//--- rtl/mem_subsys_top.sv
// --------------------------------------------------------------------------
// memory stage with l1 data cache, bus arbiter and backing ram
// op_req to op_ack latency varies with hit, miss and uncached access
// --------------------------------------------------------------------------
module mem_subsys_top import core_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  logic    op_req,
	input  mem_op_t op,
	output logic    op_ack,
	output wb_res_t res
);

	// stage to cache
	logic        c_req;
	bus_req_t    c_bus;
	logic        c_ack;
	logic [31:0] c_rdata;
	// uncached port, arbiter master 1
	logic        u_req;
	bus_req_t    u_bus;
	logic        u_ack;
	// cache bus port, arbiter master 0
	logic        m0_req;
	bus_req_t    m0;
	logic        m0_ack;
	// arbiter to ram
	logic        s_req;
	bus_req_t    s;
	logic        s_ack;
	// ram read data, shared by both masters
	logic [31:0] ram_rdata;

	mem_stage i_mem_stage (
		.clk(clk), .rst(rst),
		.op_req(op_req), .op(op), .op_ack(op_ack), .res(res),
		.c_req(c_req), .c_bus(c_bus), .c_ack(c_ack), .c_rdata(c_rdata),
		.u_req(u_req), .u_bus(u_bus), .u_ack(u_ack), .u_rdata(ram_rdata)
	);

	l1d_cache i_l1d_cache (
		.clk(clk), .rst(rst),
		.c_req(c_req), .c_bus(c_bus), .c_ack(c_ack), .c_rdata(c_rdata),
		.m_req(m0_req), .m_bus(m0), .m_ack(m0_ack), .m_rdata(ram_rdata)
	);

	mem_bus_arbiter i_arbiter (
		.clk(clk), .rst(rst),
		.m0_req(m0_req), .m1_req(u_req), .m0(m0), .m1(u_bus),
		.m0_ack(m0_ack), .m1_ack(u_ack),
		.s_req(s_req), .s(s), .s_ack(s_ack)
	);

	data_ram i_data_ram (
		.clk(clk), .rst(rst),
		.s_req(s_req), .s(s), .s_ack(s_ack), .rdata(ram_rdata)
	);

endmodule

//--- verification/tb_mem_subsys.sv
// --------------------------------------------------------------------------
// self-checking testbench of the memory stage and data memory system
// ram content is unknown after reset, so every used word is stored first
// accesses are naturally aligned
// addresses stay in a small working set
// --------------------------------------------------------------------------
`include "core_params.svh"

module tb_mem_subsys import core_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_INIT     = 40;
	localparam int N_RAND     = 200;
	localparam int CYC_PER_OP = 20;
	// a random store can expand to load, store, load
	localparam int MAX_CYCLES = (N_INIT + 3 * N_RAND) * CYC_PER_OP;

	logic    clk;
	logic    rst;
	logic    op_req;
	mem_op_t op;
	logic    op_ack;
	wb_res_t res;

	integer     seed = 32'h9c468033;
	int         cycles = 0;
	int         n_nc = 0;
	int         n_bp = 0;
	logic [7:0] ref_mem [0:(1 << `CORE_ADDR_W) - 1];

	mem_subsys_top i_dut (
		.clk(clk), .rst(rst),
		.op_req(op_req), .op(op), .op_ack(op_ack), .res(res)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// --------------------------------------------------------------------------
	// error exits
	// --------------------------------------------------------------------------
	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("*** TEST FAILED ***");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic fail_value(input string name, input logic [31:0] exp, input logic [31:0] got);
		stop_on_error($sformatf("Fail time=%0t %s expected %h got %h", $time, name, exp, got));
	endtask

	// watchdog on the whole run
	always @(posedge clk) begin
		if (!rst) begin
			cycles = cycles + 1;
			if (cycles >= MAX_CYCLES) begin
				stop_on_error("timeout, op_ack handshake did not complete in time");
			end
		end
	end

	// --------------------------------------------------------------------------
	// handshake rules at the stage input
	// --------------------------------------------------------------------------
	a_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
		$rose(op_ack) |-> op_req)
		else stop_on_error("op_ack rose while op_req was low");

	a_ack_after_req: assert property (@(posedge clk) disable iff (rst)
		$fell(op_ack) |-> !op_req)
		else stop_on_error("op_ack fell before op_req fell");

	a_res_stable: assert property (@(posedge clk) disable iff (rst)
		(op_ack && $past(op_ack)) |-> $stable(res))
		else stop_on_error("res changed while op_ack was high");

	// --------------------------------------------------------------------------
	// little-endian byte model of the ram
	// --------------------------------------------------------------------------
	function automatic logic [31:0] next_rand();
		return $random(seed);
	endfunction

	function automatic logic [31:0] model_load(logic [11:0] a, acc_size_t sz, logic sx);
		logic [31:0] v;
		case (sz)
			SZ_BYTE: v = {{24{sx & ref_mem[a][7]}}, ref_mem[a]};
			SZ_HALF: v = {{16{sx & ref_mem[a + 1][7]}}, ref_mem[a + 1], ref_mem[a]};
			default: v = {ref_mem[a + 3], ref_mem[a + 2], ref_mem[a + 1], ref_mem[a]};
		endcase
		return v;
	endfunction

	task automatic model_store(input logic [11:0] a, input acc_size_t sz, input logic [31:0] d);
		ref_mem[a] = d[7:0];
		if (sz != SZ_BYTE) begin
			ref_mem[a + 1] = d[15:8];
		end
		if (sz == SZ_WORD) begin
			ref_mem[a + 2] = d[23:16];
			ref_mem[a + 3] = d[31:24];
		end
	endtask

	// --------------------------------------------------------------------------
	// one four-phase transaction sampled on the falling edge
	// --------------------------------------------------------------------------
	task automatic run_op(input mem_op_t o, output wb_res_t r);
		@(posedge clk);
		op     <= o;
		op_req <= 1'b1;
		do @(negedge clk); while (!op_ack);
		r = res;
		@(posedge clk);
		op_req <= 1'b0;
		do @(negedge clk); while (op_ack);
	endtask

	task automatic check_res(input mem_op_t o, input wb_res_t r, input logic [31:0] exp);
		assert (r.valid === 1'b1) else fail_value("res.valid", 32'd1, {31'd0, r.valid});
		assert (r.rd === o.rd) else fail_value("res.rd", {27'd0, o.rd}, {27'd0, r.rd});
		assert (r.reg_we === o.reg_we)
			else fail_value("res.reg_we", {31'd0, o.reg_we}, {31'd0, r.reg_we});
		assert (r.data === exp) else fail_value("res.data", exp, r.data);
	endtask

	// working set of 32 cacheable words over 8 lines and 8 uncached words
	task automatic pick_addr(input acc_size_t sz, input logic nc, output logic [11:0] a);
		logic [31:0] rnd;
		rnd = next_rand();
		if (nc) begin
			a = `CORE_NC_BASE + {rnd[2:0], 2'b00};
		end else begin
			a = {5'd0, rnd[4:0], 2'b00};
		end
		case (sz)
			SZ_BYTE: a[1:0] = rnd[9:8];
			SZ_HALF: a[1] = rnd[8];
			default: ;
		endcase
	endtask

	task automatic do_access(input logic st, input acc_size_t sz, input logic [11:0] a);
		mem_op_t     o;
		wb_res_t     r;
		logic [31:0] rnd;
		logic [31:0] exp;
		rnd          = next_rand();
		o            = '0;
		o.valid      = 1'b1;
		o.load       = !st;
		o.store      = st;
		o.size       = sz;
		o.sign_ext   = rnd[0];
		o.reg_we     = !st && rnd[1];
		o.rd         = rnd[8:4];
		o.alu_result = {20'd0, a};
		o.st_data    = next_rand();
		o.bp_data    = next_rand();
		// roughly one store in four takes the write-back bypass
		o.bp_sel     = st && (rnd[13:12] == 2'd0);
		exp = st ? o.alu_result : model_load(a, sz, o.sign_ext);
		run_op(o, r);
		check_res(o, r, exp);
		if (st) begin
			model_store(a, sz, o.bp_sel ? o.bp_data : o.st_data);
		end
		if ((a & ~`CORE_NC_MASK) == `CORE_NC_BASE) begin
			n_nc = n_nc + 1;
		end
		if (o.bp_sel) begin
			n_bp = n_bp + 1;
		end
	endtask

	// non-memory op returns alu_result
	task automatic do_alu_op();
		mem_op_t     o;
		wb_res_t     r;
		logic [31:0] rnd;
		rnd          = next_rand();
		o            = '0;
		o.valid      = 1'b1;
		o.reg_we     = rnd[0];
		o.rd         = rnd[8:4];
		o.alu_result = next_rand();
		o.st_data    = next_rand();
		run_op(o, r);
		check_res(o, r, o.alu_result);
	endtask

	// --------------------------------------------------------------------------
	// stimulus
	// --------------------------------------------------------------------------
	initial begin
		logic [31:0] rnd;
		logic [11:0] a;
		acc_size_t   sz;
		logic        nc;
		rst    = 1'b1;
		op_req = 1'b0;
		op     = '0;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		assert (op_ack === 1'b0) else stop_on_error("op_ack not low after reset");
		// fill the cacheable then the uncached working set
		for (int w = 0; w < 32; w++) begin
			do_access(1'b1, SZ_WORD, 12'(w * 4));
		end
		for (int w = 0; w < 8; w++) begin
			do_access(1'b1, SZ_WORD, `CORE_NC_BASE + 12'(w * 4));
		end
		// counters track the random phase only
		n_nc = 0;
		n_bp = 0;
		for (int i = 0; i < N_RAND; i++) begin
			rnd = next_rand();
			nc  = (rnd[6:5] == 2'd0);
			sz  = acc_size_t'(rnd[9:8] % 2'd3);
			pick_addr(sz, nc, a);
			if (rnd % 10 < 2) begin
				do_alu_op();
			end else if (rnd % 10 < 6) begin
				do_access(1'b0, sz, a);
			end else if (!nc && rnd[12]) begin
				// line filled first so the store is a write hit
				do_access(1'b0, SZ_WORD, {a[11:2], 2'b00});
				do_access(1'b1, sz, a);
				do_access(1'b0, sz, a);
			end else begin
				do_access(1'b1, sz, a);
			end
		end
		if (n_nc > 0 && n_bp > 0) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			stop_on_error("no uncached access or no bypass store was issued");
		end
	end

endmodule

//--- compile.f
+incdir+rtl
rtl/core_pkg.sv
rtl/mem_stage.sv
rtl/l1d_cache.sv
rtl/mem_bus_arbiter.sv
rtl/data_ram.sv
rtl/mem_subsys_top.sv
verification/tb_mem_subsys.sv
